//--- source/x86_isa_pkg.sv
// 8086 encoding only. Register codes 0-7 follow the 8086 order, segments sit at 8-11, NONE is 12
package x86_isa_pkg;

    typedef logic [7:0] opcode_t;

    // ModR/M byte as it arrives from the fetch stream
    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_field;  // Register or opcode extension
        logic [2:0] rm;
    } modrm_t;

    typedef enum logic [3:0] {
        REG_AX   = 4'd0,
        REG_CX   = 4'd1,
        REG_DX   = 4'd2,
        REG_BX   = 4'd3,
        REG_SP   = 4'd4,
        REG_BP   = 4'd5,
        REG_SI   = 4'd6,
        REG_DI   = 4'd7,
        REG_ES   = 4'd8,        // Segment codes are 8 plus the sreg field
        REG_CS   = 4'd9,
        REG_SS   = 4'd10,
        REG_DS   = 4'd11,
        REG_NONE = 4'd12        // No register in this slot
    } reg_code_t;

    // High bit of a register code marks a segment register
    localparam logic [3:0] SREG_FLAG = 4'b1000;

    // ModR/M mod field values
    localparam logic [1:0] MOD_NO_DISP   = 2'd0;
    localparam logic [1:0] MOD_DISP_BYTE = 2'd1;
    localparam logic [1:0] MOD_DISP_WORD = 2'd2;
    localparam logic [1:0] MOD_REGISTER  = 2'd3;

    // rm value that means a direct address when mod is 00
    localparam logic [2:0] RM_DIRECT = 3'd6;

endpackage

//--- source/decode_pkg.sv
// Decoder-internal classes and the final result; register codes come from x86_isa_pkg
package decode_pkg;

    // Where the displacement size comes from
    typedef enum logic [1:0] {
        DISP_NONE  = 2'd0,
        DISP_MODRM = 2'd1,      // Follows the ModR/M rules
        DISP_BYTE  = 2'd2,
        DISP_WORD  = 2'd3
    } disp_kind_e;

    // How an operand register code is built
    typedef enum logic [2:0] {
        SEL_ZERO  = 3'd0,       // Code 0
        SEL_REG   = 3'd1,       // {0, reg}
        SEL_RM    = 3'd2,       // {0, rm}
        SEL_OPLOW = 3'd3,       // {0, opcode[2:0]}
        SEL_SREG  = 3'd4        // {1, reg}
    } reg_sel_e;

    // Format class of one opcode
    typedef struct packed {
        logic       need_modrm;
        logic       need_imm;
        logic       imm_word;
        disp_kind_e disp_kind;
        reg_sel_e   dst_sel;
        reg_sel_e   src_sel;
        logic       byte_word;
        logic       undecoded;
        logic [2:0] op_low;     // Opcode low bits for SEL_OPLOW
    } opcode_class_t;

    // Everything derived from the ModR/M byte alone
    typedef struct packed {
        logic [2:0]            reg_field;
        logic [2:0]            rm;
        logic                  is_register;
        logic                  disp_present;
        logic                  disp_word;
        x86_isa_pkg::reg_code_t ea_base;
        x86_isa_pkg::reg_code_t ea_index;
    } ea_info_t;

    // Decode result handed to the fetch unit
    typedef struct packed {
        logic                  need_modrm;
        logic                  need_disp;
        logic                  disp_word;
        logic                  need_imm;
        logic                  imm_word;
        x86_isa_pkg::reg_code_t dst;
        x86_isa_pkg::reg_code_t src;
        logic                  byte_word;
        x86_isa_pkg::reg_code_t ea_base;
        x86_isa_pkg::reg_code_t ea_index;
        logic                  undecoded;
    } decode_result_t;

endpackage

//--- source/opcode_classifier.sv
// Covers the kept 8086 groups only; ENTER, group F6/F7/FE/FF and ESC opcodes report undecoded
`timescale 1ns/100ps

module opcode_classifier
(
    input  x86_isa_pkg::opcode_t      opcode,
    output decode_pkg::opcode_class_t cls
);

    decode_pkg::reg_sel_e dir_dst;
    decode_pkg::reg_sel_e dir_src;
    logic                 w_bit;

    // D bit picks which side of an R/M-R form is the register
    assign dir_dst = opcode[1] ? decode_pkg::SEL_REG : decode_pkg::SEL_RM;
    assign dir_src = opcode[1] ? decode_pkg::SEL_RM : decode_pkg::SEL_REG;

    // MOV R IMM and MOV sreg keep W in bit 3
    assign w_bit = (opcode[7:4] == 4'b1011 || opcode[7:2] == 6'b100011) ? opcode[3] : opcode[0];

    always_comb
    begin
        cls           = '0;
        cls.byte_word = w_bit;
        cls.op_low    = opcode[2:0];

        casez (opcode)
            8'b00??_?0??:                                   // ALU R/M R
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.dst_sel    = dir_dst;
                cls.src_sel    = dir_src;
            end
            8'b00??_?10?:                                   // ALU ACC IMM
            begin
                cls.need_imm = 1'b1;
                cls.imm_word = opcode[0];
            end
            8'b000?_?11?, 8'b001?_?11?:                     // Seg push/pop, prefixes, adjust
            begin
                cls.undecoded = 1'b0;
            end
            8'b0100_????:                                   // INC/DEC reg16
            begin
                cls.dst_sel = decode_pkg::SEL_OPLOW;
                cls.src_sel = decode_pkg::SEL_OPLOW;
            end
            8'b0101_????:                                   // PUSH/POP reg16
                cls.src_sel = decode_pkg::SEL_OPLOW;
            8'b0110_000?:                                   // PUSHA/POPA
                cls.undecoded = 1'b0;
            8'b0111_????, 8'b1110_0010, 8'b1110_1011:       // Jcc, LOOP, JMP short
                cls.disp_kind = decode_pkg::DISP_BYTE;
            8'b1000_00??:                                   // ALU R/M IMM
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.need_imm   = 1'b1;
                cls.imm_word   = (opcode[1:0] == 2'b01);    // Only 81 takes a word
                cls.dst_sel    = decode_pkg::SEL_RM;
            end
            8'b1000_01??, 8'b1000_10??:                     // TEST/XCHG/MOV R/M R
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.dst_sel    = dir_dst;
                cls.src_sel    = dir_src;
            end
            8'b1000_11?0:                                   // MOV R/M sreg
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.dst_sel    = opcode[1] ? decode_pkg::SEL_SREG : decode_pkg::SEL_RM;
                cls.src_sel    = opcode[1] ? decode_pkg::SEL_RM : decode_pkg::SEL_SREG;
            end
            8'b1000_1101:                                   // LEA writes reg
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.dst_sel    = decode_pkg::SEL_REG;
            end
            8'b1000_1111:                                   // POP R/M
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.dst_sel    = decode_pkg::SEL_RM;
            end
            8'b1001_0???:                                   // NOP/XCHG ACC
                cls.src_sel = decode_pkg::SEL_OPLOW;
            8'b1001_100?, 8'b1001_1011, 8'b1001_11??:       // CBW/CWD, WAIT, flag ops
                cls.undecoded = 1'b0;
            8'b1001_1010, 8'b1110_1010:                     // CALL/JMP far
            begin
                cls.disp_kind = decode_pkg::DISP_WORD;
                cls.need_imm  = 1'b1;
                cls.imm_word  = 1'b1;                       // Segment word
            end
            8'b1010_00??, 8'b1110_1000, 8'b1110_1001:       // MOV M ACC, CALL/JMP near
                cls.disp_kind = decode_pkg::DISP_WORD;
            8'b1010_100?:                                   // TEST ACC IMM
            begin
                cls.need_imm = 1'b1;
                cls.imm_word = opcode[0];
            end
            8'b1010_01??, 8'b1010_101?, 8'b1010_11??:       // String ops
                cls.undecoded = 1'b0;
            8'b1011_????:                                   // MOV R IMM
            begin
                cls.need_imm = 1'b1;
                cls.imm_word = opcode[3];
                cls.dst_sel  = decode_pkg::SEL_OPLOW;
            end
            8'b1100_000?:                                   // Shift/rotate by IMM8
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.need_imm   = 1'b1;
                cls.dst_sel    = decode_pkg::SEL_RM;
                cls.src_sel    = decode_pkg::SEL_RM;
            end
            8'b1100_0010:                                   // RET imm16
            begin
                cls.need_imm = 1'b1;
                cls.imm_word = 1'b1;
            end
            8'b1100_0011, 8'b1100_1011:                     // RET near/far
                cls.undecoded = 1'b0;
            8'b1100_010?:                                   // LES/LDS
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.src_sel    = decode_pkg::SEL_REG;
            end
            8'b1100_011?:                                   // MOV I->M
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.need_imm   = 1'b1;
                cls.imm_word   = opcode[0];
                cls.dst_sel    = decode_pkg::SEL_RM;
            end
            8'b1101_00??:                                   // Shift/rotate by 1 or CL
            begin
                cls.need_modrm = 1'b1;
                cls.disp_kind  = decode_pkg::DISP_MODRM;
                cls.dst_sel    = decode_pkg::SEL_RM;
                cls.src_sel    = decode_pkg::SEL_RM;
            end
            8'b1110_01??:                                   // IN/OUT port imm8
                cls.need_imm = 1'b1;
            8'b1111_0011, 8'b1111_1010, 8'b1111_1100:       // REP, CLI, CLD
                cls.undecoded = 1'b0;
            default:
            begin
                cls           = '0;
                cls.undecoded = 1'b1;
            end
        endcase
    end

endmodule

//--- source/modrm_decoder.sv
// 16-bit 8086 addressing only; no SIB and no 32-bit forms
`timescale 1ns/100ps

module modrm_decoder
(
    input  x86_isa_pkg::modrm_t  modrm,
    output decode_pkg::ea_info_t ea
);

    logic direct;

    // mod=00 with rm=110 is a plain 16-bit address
    assign direct = (modrm.mod == x86_isa_pkg::MOD_NO_DISP)
                    && (modrm.rm == x86_isa_pkg::RM_DIRECT);

    always_comb
    begin
        ea.reg_field    = modrm.reg_field;
        ea.rm           = modrm.rm;
        ea.is_register  = (modrm.mod == x86_isa_pkg::MOD_REGISTER);
        ea.disp_present = direct || (modrm.mod == x86_isa_pkg::MOD_DISP_BYTE)
                          || (modrm.mod == x86_isa_pkg::MOD_DISP_WORD);
        ea.disp_word    = direct || (modrm.mod == x86_isa_pkg::MOD_DISP_WORD);

        case (modrm.rm)
            3'd0, 3'd1, 3'd7: ea.ea_base = x86_isa_pkg::REG_BX;
            3'd2, 3'd3, 3'd6: ea.ea_base = x86_isa_pkg::REG_BP;
            default:          ea.ea_base = x86_isa_pkg::REG_NONE;   // SI or DI alone
        endcase

        case (modrm.rm)
            3'd0, 3'd2, 3'd4: ea.ea_index = x86_isa_pkg::REG_SI;
            3'd1, 3'd3, 3'd5: ea.ea_index = x86_isa_pkg::REG_DI;
            default:          ea.ea_index = x86_isa_pkg::REG_NONE;
        endcase

        // Register operands and direct addresses use no EA registers
        if (ea.is_register || direct)
        begin
            ea.ea_base  = x86_isa_pkg::REG_NONE;
            ea.ea_index = x86_isa_pkg::REG_NONE;
        end
    end

endmodule

//--- source/operand_resolver.sv
// EA registers are reported only for opcodes that take a ModR/M byte
`timescale 1ns/100ps

module operand_resolver
(
    input  decode_pkg::opcode_class_t  cls,
    input  decode_pkg::ea_info_t       ea,
    output decode_pkg::decode_result_t result
);

    // Turns an operand selector into a register code
    function automatic x86_isa_pkg::reg_code_t sel_code
    (
        input decode_pkg::reg_sel_e sel,
        input logic [2:0]           reg_field,
        input logic [2:0]           rm,
        input logic [2:0]           op_low
    );
        case (sel)
            decode_pkg::SEL_REG:   return x86_isa_pkg::reg_code_t'({1'b0, reg_field});
            decode_pkg::SEL_RM:    return x86_isa_pkg::reg_code_t'({1'b0, rm});
            decode_pkg::SEL_OPLOW: return x86_isa_pkg::reg_code_t'({1'b0, op_low});
            decode_pkg::SEL_SREG:
                return x86_isa_pkg::reg_code_t'(x86_isa_pkg::SREG_FLAG | {1'b0, reg_field});
            default:               return x86_isa_pkg::REG_AX;   // Code 0
        endcase
    endfunction

    always_comb
    begin
        result.need_modrm = cls.need_modrm;
        result.need_imm   = cls.need_imm;
        result.imm_word   = cls.imm_word;
        result.byte_word  = cls.byte_word;
        result.undecoded  = cls.undecoded;
        result.dst        = sel_code(cls.dst_sel, ea.reg_field, ea.rm, cls.op_low);
        result.src        = sel_code(cls.src_sel, ea.reg_field, ea.rm, cls.op_low);

        case (cls.disp_kind)
            decode_pkg::DISP_MODRM: result.need_disp = ea.disp_present;
            decode_pkg::DISP_NONE:  result.need_disp = 1'b0;
            default:                result.need_disp = 1'b1;    // Fixed byte or word
        endcase

        case (cls.disp_kind)
            decode_pkg::DISP_MODRM: result.disp_word = ea.disp_word;
            decode_pkg::DISP_WORD:  result.disp_word = 1'b1;
            default:                result.disp_word = 1'b0;
        endcase

        // Without ModR/M the byte on the modrm input is not part of this instruction
        result.ea_base  = cls.need_modrm ? ea.ea_base : x86_isa_pkg::REG_NONE;
        result.ea_index = cls.need_modrm ? ea.ea_index : x86_isa_pkg::REG_NONE;
    end

endmodule

//--- source/x86_decode.sv
// Purely combinational; result is valid once opcode and modrm settle
`timescale 1ns/100ps

module x86_decode
(
    input  x86_isa_pkg::opcode_t       opcode,
    input  x86_isa_pkg::modrm_t        modrm,
    output decode_pkg::decode_result_t result
);

    decode_pkg::opcode_class_t cls;
    decode_pkg::ea_info_t      ea;

    opcode_classifier u_classifier
    (
        .opcode (opcode),
        .cls    (cls)
    );

    modrm_decoder u_modrm
    (
        .modrm  (modrm),
        .ea     (ea)
    );

    operand_resolver u_resolver
    (
        .cls    (cls),
        .ea     (ea),
        .result (result)
    );

endmodule

//--- bench/bench_clock.sv
// Free-running bench clock, 100 ns period, starts low at time 0
`timescale 1ns/100ps

module bench_clock
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // Half of the 100 ns period
    end

endmodule

//--- bench/x86_decode_tb.sv
// Run from the project root; reads 13 hex fields per vector line of bench/decode_patterns.txt
`timescale 1ns/100ps

module x86_decode_tb;

    localparam int RANDOM_COUNT = 64;
    localparam int RESET_CYCLES = 3;
    localparam int MARGIN       = 20;

    logic                       clk;
    logic                       rst;
    x86_isa_pkg::opcode_t       opcode;
    x86_isa_pkg::modrm_t        modrm;
    decode_pkg::decode_result_t result;

    logic [7:0]                 op_q[$];
    logic [7:0]                 modrm_q[$];
    decode_pkg::decode_result_t exp_q[$];
    string                      load_error;
    int                         pass_count;
    int                         fail_count;
    int                         cycle_count;
    int                         limit;
    int                         seed;

    bench_clock u_clock
    (
        .clk (clk)
    );

    x86_decode dut
    (
        .opcode (opcode),
        .modrm  (modrm),
        .result (result)
    );

    // Bench copy of the 8086 rm table as {need_disp, base, index}
    function automatic logic [8:0] expected_ea(input logic [7:0] m);
        logic [3:0] base;
        logic [3:0] index;
        logic       direct;
        case (m[2:0])
            3'd0:    {base, index} = {4'd3, 4'd6};     // BX+SI
            3'd1:    {base, index} = {4'd3, 4'd7};     // BX+DI
            3'd2:    {base, index} = {4'd5, 4'd6};     // BP+SI
            3'd3:    {base, index} = {4'd5, 4'd7};     // BP+DI
            3'd4:    {base, index} = {4'd12, 4'd6};
            3'd5:    {base, index} = {4'd12, 4'd7};
            3'd6:    {base, index} = {4'd5, 4'd12};
            default: {base, index} = {4'd3, 4'd12};
        endcase
        direct = (m[7:6] == 2'd0) && (m[2:0] == 3'd6);
        if (direct || m[7:6] == 2'd3)
            {base, index} = {4'd12, 4'd12};            // Register operand or direct address
        return {direct || m[7:6] == 2'd1 || m[7:6] == 2'd2, base, index};
    endfunction

    task automatic load_patterns();
        int                         fd;
        int                         n;
        string                      line;
        logic [7:0]                 f [13];
        decode_pkg::decode_result_t exp;
        fd = $fopen("bench/decode_patterns.txt", "r");
        if (fd == 0)
        begin
            load_error = "Could not open bench/decode_patterns.txt";
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12]);
            if (n != 13)
            begin
                load_error = {"Pattern line does not hold 13 hex fields: ", line};
                break;
            end
            // Field order of decode_result_t
            exp = {f[2][0], f[3][0], f[4][0], f[5][0], f[6][0], f[7][3:0], f[8][3:0],
                   f[9][0], f[10][3:0], f[11][3:0], f[12][0]};
            op_q.push_back(f[0]);
            modrm_q.push_back(f[1]);
            exp_q.push_back(exp);
        end
        $fclose(fd);
        if (load_error == "" && op_q.size() == 0)
            load_error = "Pattern file holds no vectors";
    endtask

    // Inputs change on the falling edge and result is sampled on the next rising edge
    task automatic apply_vector(input logic [7:0] op, input logic [7:0] m);
        @(negedge clk);
        opcode = op;
        modrm  = m;
        @(posedge clk);
    endtask

    task automatic run_patterns();
        for (int i = 0; i < op_q.size(); i++)
        begin
            apply_vector(op_q[i], modrm_q[i]);
            if (result !== exp_q[i])
            begin
                $display("[FAIL] t=%0t pattern %0d op=%h modrm=%h got %h expected %h",
                         $time, i, op_q[i], modrm_q[i], result, exp_q[i]);
                fail_count++;
            end
            else
            begin
                $display("pattern %0d op=%h modrm=%h ok", i, op_q[i], modrm_q[i]);
                pass_count++;
            end
        end
    endtask

    task automatic run_random_ea();
        logic [7:0] m;
        logic [8:0] exp_ea;
        int         errors;
        errors = 0;
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            m      = 8'($random(seed));
            exp_ea = expected_ea(m);
            apply_vector(8'h8B, m);                     // MOV r16, r/m16
            if ({result.need_disp, result.ea_base, result.ea_index} !== exp_ea)
            begin
                $display("[FAIL] t=%0t random EA modrm=%h got %h expected %h", $time, m,
                         {result.need_disp, result.ea_base, result.ea_index}, exp_ea);
                errors++;
            end
        end
        if (errors == 0)
        begin
            $display("random EA %0d vectors ok", RANDOM_COUNT);
            pass_count++;
        end
        else
        begin
            $display("random EA %0d of %0d vectors wrong", errors, RANDOM_COUNT);
            fail_count++;
        end
    endtask

    initial
    begin
        opcode     = '0;
        modrm      = '0;
        rst        = 1'b1;
        seed       = 734;
        pass_count = 0;
        fail_count = 0;
        load_error = "";
        load_patterns();
        limit = op_q.size() + RANDOM_COUNT + RESET_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        rst = 1'b0;
        if (load_error == "")
        begin
            run_patterns();
            run_random_ea();
        end
        else
        begin
            $display("%s", load_error);
            fail_count++;
        end
        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Cycle budget covers every vector plus reset and a margin
    initial
    begin
        cycle_count = 0;
        wait (limit > 0);
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped by timeout after %0d cycles", cycle_count);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- x86_decode.f
source/x86_isa_pkg.sv
source/decode_pkg.sv
source/opcode_classifier.sv
source/modrm_decoder.sv
source/operand_resolver.sv
source/x86_decode.sv
bench/bench_clock.sv
bench/x86_decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the x86_decode regression with Verilator from the project root

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f x86_decode.f --top-module x86_decode_tb \
    -o x86_decode_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see sim.log"
    exit 1
fi

./obj_dir/x86_decode_sim >> sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- bench/decode_patterns.txt
# opcode modrm need_modrm need_disp disp_word need_imm imm_word dst src byte_word ea_base ea_index undecoded
# all hex; register codes 0-7 AX..DI, 8-b ES..DS, c none
00 d8 1 0 0 0 0 0 3 0 c c 0
03 d8 1 0 0 0 0 3 0 1 c c 0
28 ca 1 0 0 0 0 2 1 0 c c 0
2b ca 1 0 0 0 0 1 2 1 c c 0
04 00 0 0 0 1 0 0 0 0 c c 0
05 00 0 0 0 1 1 0 0 1 c c 0
80 c1 1 0 0 1 0 1 0 0 c c 0
81 c1 1 0 0 1 1 1 0 1 c c 0
83 c1 1 0 0 1 0 1 0 1 c c 0
b3 00 0 0 0 1 0 3 0 0 c c 0
bf 00 0 0 0 1 1 7 0 1 c c 0
c2 00 0 0 0 1 1 0 0 0 c c 0
c6 47 1 1 0 1 0 7 0 0 3 c 0
c7 06 1 1 1 1 1 6 0 1 c c 0
e4 00 0 0 0 1 0 0 0 0 c c 0
9a 00 0 1 1 1 1 0 0 0 c c 0
8b 00 1 0 0 0 0 0 0 1 3 6 0
8b 4a 1 1 0 0 0 1 2 1 5 6 0
8b 9c 1 1 1 0 0 3 4 1 c 6 0
8b e5 1 0 0 0 0 4 5 1 c c 0
8b 1e 1 1 1 0 0 3 6 1 c c 0
70 00 0 1 0 0 0 0 0 0 c c 0
eb 00 0 1 0 0 0 0 0 1 c c 0
e2 00 0 1 0 0 0 0 0 0 c c 0
e8 00 0 1 1 0 0 0 0 0 c c 0
e9 00 0 1 1 0 0 0 0 1 c c 0
ea 00 0 1 1 1 1 0 0 0 c c 0
a0 00 0 1 1 0 0 0 0 0 c c 0
8c d8 1 0 0 0 0 0 b 1 c c 0
8e c2 1 0 0 0 0 8 2 1 c c 0
8c 0f 1 0 0 0 0 7 9 1 3 c 0
43 00 0 0 0 0 0 3 3 1 c c 0
55 00 0 0 0 0 0 0 5 1 c c 0
92 00 0 0 0 0 0 0 2 0 c c 0
c8 00 0 0 0 0 0 0 0 0 c c 1
f6 00 0 0 0 0 0 0 0 0 c c 1
ff 00 0 0 0 0 0 0 0 0 c c 1
d8 00 0 0 0 0 0 0 0 0 c c 1
